// File: source/riscv_branch_pkg.sv
// ISA-side types: pc, instruction id, funct3, exception cause and branch issue inputs
`default_nettype none

package riscv_branch_pkg;

    //////////////////////////////
    // Basic widths
    //////////////////////////////
    typedef logic [31:0] pc_t;
    typedef logic [2:0] id_t;

    // Bit 2 selects less-than, bit 1 unsigned, bit 0 inverts
    typedef logic [2:0] fn3_t;

    typedef logic [4:0] exc_code_t;

    // Cause code for a taken target off a 4-byte boundary
    localparam exc_code_t INST_ADDR_MISALIGNED = 5'd0;

    //////////////////////////////
    // Issue stage inputs
    //////////////////////////////
    typedef struct packed {
        logic [31:0] rs1;
        logic [31:0] rs2;
        pc_t issue_pc;
        pc_t pc_p4;
        // Sign extended before the add
        logic signed [20:0] pc_offset;
        fn3_t fn3;
        logic jal;
        logic jalr;
        logic is_call;
        logic is_return;
        // Next instruction is in issue, issue_pc is its pc
        logic issue_pc_valid;
    } branch_inputs_t;

endpackage

`default_nettype wire

// File: source/branch_predict_pkg.sv
// Predictor-side types: branch result record, BTB entry, request, response and index helpers
`default_nettype none

package branch_predict_pkg;

    import riscv_branch_pkg::*;

    // Sized for the largest table of 1024 entries
    localparam int unsigned BTB_TAG_W = 20;
    localparam int unsigned BTB_IDX_W = 10;

    typedef logic [BTB_TAG_W-1:0] btb_tag_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;

    typedef struct packed {
        id_t id;
        logic valid;
        pc_t pc;
        pc_t target_pc;
        logic branch_taken;
        logic is_branch;
        logic is_return;
        logic is_call;
    } branch_results_t;

    typedef struct packed {
        logic valid;
        btb_tag_t tag;
        pc_t target;
    } btb_entry_t;

    // Shared by the update and lookup requesters
    typedef struct packed {
        logic write;
        btb_idx_t index;
        btb_entry_t entry;
    } btb_req_t;

    typedef struct packed {
        btb_entry_t entry;
    } btb_rsp_t;

    // Word index, low idx_w bits above the byte offset
    function automatic btb_idx_t btb_index(pc_t pc, int unsigned idx_w);
        return btb_idx_t'((pc >> 2) & ((32'd1 << idx_w) - 32'd1));
    endfunction

    // Tag starts just above the index bits
    function automatic btb_tag_t btb_tag(pc_t pc, int unsigned idx_w);
        return btb_tag_t'(pc >> (idx_w + 2));
    endfunction

endpackage

`default_nettype wire

// File: source/branch_unit.sv
// Branch unit: comparison, target, misprediction flush, misaligned exception, BTB update
`default_nettype none

module branch_unit #(
    parameter bit INCLUDE_M_MODE = 1'b1,
    parameter int unsigned BTB_ENTRIES = 64
) (
    input wire logic clk,
    input wire logic rst,

    input wire logic issue_new_request,
    input wire riscv_branch_pkg::id_t issue_id,
    input wire riscv_branch_pkg::branch_inputs_t branch_inputs,

    output branch_predict_pkg::branch_results_t br_results,
    output logic branch_flush,

    output logic exception_valid,
    input wire logic exception_ack,
    output riscv_branch_pkg::id_t exception_id,
    output riscv_branch_pkg::exc_code_t exception_code,
    output riscv_branch_pkg::pc_t exception_tval,

    output logic update_req,
    input wire logic update_gnt,
    output branch_predict_pkg::btb_req_t update,

    output logic tr_branch_correct,
    output logic tr_branch_mispredict,
    output logic tr_return_correct,
    output logic tr_return_mispredict
);

    import riscv_branch_pkg::*;
    import branch_predict_pkg::*;

    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

    // Signed or unsigned less-than, else equality; fn3[0] inverts
    function automatic logic branch_compare(fn3_t fn3, logic [31:0] a, logic [31:0] b);
        logic lt;
        logic res;
        lt = fn3[1] ? (a < b) : ($signed(a) < $signed(b));
        res = fn3[2] ? lt : (a == b);
        return res ^ fn3[0];
    endfunction

    logic branch_taken;
    pc_t jump_pc;
    pc_t new_pc;
    pc_t new_pc_aligned;
    logic branch_pending;
    logic completing;

    // State captured at issue
    logic taken_ex;
    pc_t new_pc_ex;
    pc_t pc_ex;
    id_t id_ex;
    logic jal_jalr_ex;
    logic is_return_ex;
    logic is_call_ex;

    //////////////////////////////
    // Target and decision
    //////////////////////////////
    assign branch_taken = branch_compare(branch_inputs.fn3, branch_inputs.rs1, branch_inputs.rs2)
        | branch_inputs.jal | branch_inputs.jalr;

    assign jump_pc = (branch_inputs.jalr ? branch_inputs.rs1 : branch_inputs.issue_pc)
        + {{11{branch_inputs.pc_offset[20]}}, branch_inputs.pc_offset};
    assign new_pc = branch_taken ? jump_pc : branch_inputs.pc_p4;
    // jalr drops bit 0 of the sum
    assign new_pc_aligned = {new_pc[31:1], new_pc[0] & ~branch_inputs.jalr};

    always_ff @(posedge clk) begin
        if (issue_new_request) begin
            taken_ex <= branch_taken;
            new_pc_ex <= new_pc_aligned;
            pc_ex <= branch_inputs.issue_pc;
            id_ex <= issue_id;
            jal_jalr_ex <= branch_inputs.jal | branch_inputs.jalr;
            is_return_ex <= branch_inputs.is_return;
            is_call_ex <= branch_inputs.is_call;
        end
    end

    // Waits for the next instruction to reach issue; a new branch wins over clear
    always_ff @(posedge clk) begin
        if (rst)
            branch_pending <= 1'b0;
        else if (issue_new_request)
            branch_pending <= 1'b1;
        else if (branch_inputs.issue_pc_valid || exception_valid)
            branch_pending <= 1'b0;
    end

    assign completing = branch_pending & branch_inputs.issue_pc_valid;

    //////////////////////////////
    // Resolution
    //////////////////////////////
    assign branch_flush = completing && (branch_inputs.issue_pc[31:1] != new_pc_ex[31:1]);

    assign br_results.id = id_ex;
    assign br_results.valid = completing;
    assign br_results.pc = pc_ex;
    assign br_results.target_pc = new_pc_ex;
    assign br_results.branch_taken = taken_ex;
    assign br_results.is_branch = ~jal_jalr_ex;
    assign br_results.is_return = is_return_ex;
    assign br_results.is_call = is_call_ex;

    // Exactly one pulse per completing branch
    assign tr_branch_correct = completing & ~is_return_ex & ~branch_flush;
    assign tr_branch_mispredict = completing & ~is_return_ex & branch_flush;
    assign tr_return_correct = completing & is_return_ex & ~branch_flush;
    assign tr_return_mispredict = completing & is_return_ex & branch_flush;

    //////////////////////////////
    // Misaligned target exception
    //////////////////////////////
    generate
        if (INCLUDE_M_MODE) begin : gen_exception
            logic new_exception;

            assign new_exception = issue_new_request & branch_taken & new_pc_aligned[1];

            // Held until ack; a new exception beats the ack
            always_ff @(posedge clk) begin
                if (rst)
                    exception_valid <= 1'b0;
                else
                    exception_valid <= new_exception | (exception_valid & ~exception_ack);
            end

            always_ff @(posedge clk) begin
                if (new_exception) begin
                    exception_id <= issue_id;
                    exception_tval <= new_pc_aligned;
                end
            end

            assign exception_code = INST_ADDR_MISALIGNED;
        end else begin : gen_no_exception
            // Misaligned targets are just taken
            assign exception_valid = 1'b0;
            assign exception_id = '0;
            assign exception_code = INST_ADDR_MISALIGNED;
            assign exception_tval = '0;
        end
    endgenerate

    //////////////////////////////
    // BTB update queue
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)
            update_req <= 1'b0;
        else
            update_req <= completing | (update_req & ~update_gnt);
    end

    // Not-taken resolution invalidates the entry
    always_ff @(posedge clk) begin
        if (completing) begin
            update.write <= 1'b1;
            update.index <= btb_index(pc_ex, IDX_W);
            update.entry.valid <= taken_ex;
            update.entry.tag <= btb_tag(pc_ex, IDX_W);
            update.entry.target <= new_pc_ex;
        end
    end

    // Single-entry queue is never refilled before its grant
    assert property (@(posedge clk) disable iff (rst)
        completing |-> !update_req || update_gnt);

    // Ack only answers a raised exception
    assert property (@(posedge clk) disable iff (rst)
        exception_ack |-> exception_valid);

endmodule

`default_nettype wire

// File: source/btb_arbiter.sv
// BTB port arbiter: fixed priority, update ahead of lookup
`default_nettype none

module btb_arbiter (
    input wire logic clk,
    input wire logic rst,

    input wire logic update_req,
    input wire branch_predict_pkg::btb_req_t update,
    output logic update_gnt,

    input wire logic lookup_req,
    input wire branch_predict_pkg::btb_req_t lookup,
    output logic lookup_gnt,

    input wire logic ram_busy,
    output logic ram_en,
    output branch_predict_pkg::btb_req_t ram_req
);

    import branch_predict_pkg::*;

    // Set in the cycle the lookup read data sits on ram_rsp
    logic lookup_rd_r;

    //////////////////////////////
    // Grant
    //////////////////////////////
    // Nothing goes through while the table sweeps
    assign update_gnt = update_req & ~ram_busy;
    assign lookup_gnt = lookup_req & ~update_req & ~ram_busy;

    assign ram_en = update_gnt | lookup_gnt;
    assign ram_req = update_gnt ? update : lookup;

    always_ff @(posedge clk) begin
        if (rst)
            lookup_rd_r <= 1'b0;
        else
            lookup_rd_r <= lookup_gnt;
    end

    // Requesters hold their request until granted
    assert property (@(posedge clk) disable iff (rst)
        update_req && !update_gnt |=> update_req);

    assert property (@(posedge clk) disable iff (rst)
        lookup_req && !lookup_gnt |=> lookup_req);

    // Predictor takes its data before asking again
    assert property (@(posedge clk) disable iff (rst)
        lookup_rd_r |-> !lookup_gnt);

endmodule

`default_nettype wire

// File: source/btb_ram.sv
// BTB table: single-port tag/target memory with registered read and reset sweep
`default_nettype none

module btb_ram #(
    parameter int unsigned BTB_ENTRIES = 64
) (
    input wire logic clk,
    input wire logic rst,

    input wire logic ram_en,
    input wire branch_predict_pkg::btb_req_t ram_req,
    output branch_predict_pkg::btb_rsp_t ram_rsp,
    output logic ram_busy
);

    import branch_predict_pkg::*;

    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

    typedef enum logic {
        SWEEP,
        READY
    } ram_state_t;

    ram_state_t state;
    logic [IDX_W-1:0] sweep_idx;
    btb_entry_t mem [BTB_ENTRIES];

    //////////////////////////////
    // Reset sweep
    //////////////////////////////
    // One entry per cycle, BTB_ENTRIES cycles in all
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SWEEP;
            sweep_idx <= '0;
        end else if (state == SWEEP) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == IDX_W'(BTB_ENTRIES - 1))
                state <= READY;
        end
    end

    assign ram_busy = (state == SWEEP);

    //////////////////////////////
    // Table access
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (state == SWEEP)
            mem[sweep_idx] <= '0;
        else if (ram_en && ram_req.write)
            mem[ram_req.index[IDX_W-1:0]] <= ram_req.entry;
    end

    // Read data shows up the cycle after the grant
    always_ff @(posedge clk) begin
        if (ram_en && !ram_req.write)
            ram_rsp.entry <= mem[ram_req.index[IDX_W-1:0]];
    end

    // Arbiter must hold off while the sweep runs
    assert property (@(posedge clk) disable iff (rst)
        ram_busy |-> !ram_en);

endmodule

`default_nettype wire

// File: source/fetch_predictor.sv
// Fetch predictor: BTB lookup FSM, tag compare and next pc prediction
`default_nettype none

module fetch_predictor #(
    parameter int unsigned BTB_ENTRIES = 64
) (
    input wire logic clk,
    input wire logic rst,

    input wire logic fetch_req,
    input wire riscv_branch_pkg::pc_t fetch_pc,

    output logic lookup_req,
    input wire logic lookup_gnt,
    output branch_predict_pkg::btb_req_t lookup,
    input wire branch_predict_pkg::btb_rsp_t ram_rsp,

    output logic predict_valid,
    output riscv_branch_pkg::pc_t predicted_pc,
    output logic predicted_taken
);

    import riscv_branch_pkg::*;
    import branch_predict_pkg::*;

    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_DATA
    } fetch_state_t;

    fetch_state_t state;
    pc_t fetch_pc_r;
    logic hit;

    //////////////////////////////
    // Lookup FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:
                    if (fetch_req)
                        state <= REQUEST;
                // Stays here while updates take the port
                REQUEST:
                    if (lookup_gnt)
                        state <= WAIT_DATA;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Captured only when a new lookup starts
    always_ff @(posedge clk) begin
        if (state == IDLE && fetch_req)
            fetch_pc_r <= fetch_pc;
    end

    assign lookup_req = (state == REQUEST);
    assign lookup.write = 1'b0;
    assign lookup.index = btb_index(fetch_pc_r, IDX_W);
    assign lookup.entry = '0;

    //////////////////////////////
    // Prediction
    //////////////////////////////
    assign hit = ram_rsp.entry.valid && (ram_rsp.entry.tag == btb_tag(fetch_pc_r, IDX_W));

    // Valid for the single cycle the read data is present
    assign predict_valid = (state == WAIT_DATA);
    assign predicted_taken = hit;
    assign predicted_pc = hit ? ram_rsp.entry.target : fetch_pc_r + 32'd4;

    // One lookup at a time, extra requests are lost
    assert property (@(posedge clk) disable iff (rst)
        fetch_req |-> state == IDLE);

endmodule

`default_nettype wire

// File: source/branch_predict_top.sv
// Top level: branch unit, BTB arbiter, BTB table and fetch predictor
`default_nettype none

module branch_predict_top #(
    parameter int unsigned BTB_ENTRIES = 64,
    parameter bit INCLUDE_M_MODE = 1'b1
) (
    input wire logic clk,
    input wire logic rst,

    // Issue side
    input wire logic issue_new_request,
    input wire riscv_branch_pkg::id_t issue_id,
    input wire riscv_branch_pkg::branch_inputs_t branch_inputs,
    output branch_predict_pkg::branch_results_t br_results,
    output logic branch_flush,

    // Exception handshake
    output logic exception_valid,
    input wire logic exception_ack,
    output riscv_branch_pkg::id_t exception_id,
    output riscv_branch_pkg::exc_code_t exception_code,
    output riscv_branch_pkg::pc_t exception_tval,

    // Fetch side
    input wire logic fetch_req,
    input wire riscv_branch_pkg::pc_t fetch_pc,
    output logic predict_valid,
    output riscv_branch_pkg::pc_t predicted_pc,
    output logic predicted_taken,

    output logic tr_branch_correct,
    output logic tr_branch_mispredict,
    output logic tr_return_correct,
    output logic tr_return_mispredict
);

    import branch_predict_pkg::*;

    logic update_req;
    logic update_gnt;
    btb_req_t update;
    logic lookup_req;
    logic lookup_gnt;
    btb_req_t lookup;
    logic ram_en;
    logic ram_busy;
    btb_req_t ram_req;
    btb_rsp_t ram_rsp;

    branch_unit #(
        .INCLUDE_M_MODE(INCLUDE_M_MODE),
        .BTB_ENTRIES(BTB_ENTRIES)
    ) branch_unit_i (
        .clk, .rst,
        .issue_new_request, .issue_id, .branch_inputs,
        .br_results, .branch_flush,
        .exception_valid, .exception_ack, .exception_id, .exception_code, .exception_tval,
        .update_req, .update_gnt, .update,
        .tr_branch_correct, .tr_branch_mispredict, .tr_return_correct, .tr_return_mispredict
    );

    btb_arbiter btb_arbiter_i (
        .clk, .rst,
        .update_req, .update, .update_gnt,
        .lookup_req, .lookup, .lookup_gnt,
        .ram_busy, .ram_en, .ram_req
    );

    btb_ram #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) btb_ram_i (
        .clk, .rst,
        .ram_en, .ram_req, .ram_rsp, .ram_busy
    );

    fetch_predictor #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) fetch_predictor_i (
        .clk, .rst,
        .fetch_req, .fetch_pc,
        .lookup_req, .lookup_gnt, .lookup, .ram_rsp,
        .predict_valid, .predicted_pc, .predicted_taken
    );

endmodule

`default_nettype wire

// File: testbench/tb_branch_model.svh
// Reference model: branch compare, next pc, shadow BTB and the LCG
`ifndef TB_BRANCH_MODEL_SVH
`define TB_BRANCH_MODEL_SVH

logic [31:0] rng_state = 32'he5db72b7;

// Shadow copy of the BTB contents
logic shadow_valid [BTB_ENTRIES];
logic [19:0] shadow_tag [BTB_ENTRIES];
pc_t shadow_target [BTB_ENTRIES];

// Halves swapped so the low bits are not the weak LCG bits
function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {rng_state[15:0], rng_state[31:16]};
endfunction

// BEQ, BNE, BLT, BGE, BLTU, BGEU; jumps always taken
function automatic logic model_taken(fn3_t fn3, logic jal, logic jalr,
        logic [31:0] a, logic [31:0] b);
    logic cmp;
    case (fn3)
        3'b000: cmp = (a == b);
        3'b001: cmp = (a != b);
        3'b100: cmp = ($signed(a) < $signed(b));
        3'b101: cmp = ($signed(a) >= $signed(b));
        3'b110: cmp = (a < b);
        3'b111: cmp = (a >= b);
        default: cmp = 1'b0;
    endcase
    return cmp | jal | jalr;
endfunction

// Taken target, or the fall-through pc
function automatic pc_t model_new_pc(logic taken, logic jalr, logic [31:0] rs1, pc_t pc,
        logic [20:0] off);
    pc_t sum;
    sum = (jalr ? rs1 : pc) + {{11{off[20]}}, off};
    if (jalr)
        sum[0] = 1'b0;
    return taken ? sum : pc + 32'd4;
endfunction

function automatic int unsigned shadow_index(pc_t pc);
    return (pc >> 2) % BTB_ENTRIES;
endfunction

// Tag is whatever sits above the index bits
function automatic logic [19:0] shadow_tag_of(pc_t pc);
    return 20'(pc >> ($clog2(BTB_ENTRIES) + 2));
endfunction

function automatic void shadow_clear();
    int i;
    for (i = 0; i < BTB_ENTRIES; i++)
        shadow_valid[i] = 1'b0;
endfunction

// Not taken drops whatever entry sits at that index
function automatic void shadow_write(pc_t pc, logic taken, pc_t target);
    shadow_valid[shadow_index(pc)] = taken;
    shadow_tag[shadow_index(pc)] = shadow_tag_of(pc);
    shadow_target[shadow_index(pc)] = target;
endfunction

function automatic logic shadow_hit(pc_t pc);
    return shadow_valid[shadow_index(pc)] && (shadow_tag[shadow_index(pc)] == shadow_tag_of(pc));
endfunction

`endif

// File: testbench/tb_branch_predict_top.sv
// Testbench for branch_predict_top: clock, reset, stimulus, watchdog, checks and report
`default_nettype none

module tb_branch_predict_top;

    timeunit 1ns;
    timeprecision 1ps;

    import riscv_branch_pkg::*;
    import branch_predict_pkg::*;

    localparam int unsigned BTB_ENTRIES = 16;
    localparam int CLK_PERIOD = 10;
    localparam int ITER = 3;
    // Upper bound per branch: issue, gap of up to 3, completion, release
    localparam int N_BRANCHES = 8 * ITER + 4;
    localparam int STIM_CYCLES = N_BRANCHES * 8 + 4 * 6 + 12 + 2;
    localparam int TIMEOUT_NS = (STIM_CYCLES * 4 + BTB_ENTRIES) * CLK_PERIOD;
    localparam int LOOKUP_LIMIT = BTB_ENTRIES + 8;
    localparam pc_t TRAIN_PC = 32'h0000_1040;
    localparam pc_t ARB_PC = 32'h0000_3080;

    `include "tb_branch_model.svh"

    logic clk;
    logic rst;
    logic issue_new_request;
    id_t issue_id;
    branch_inputs_t branch_inputs;
    branch_results_t br_results;
    logic branch_flush;
    logic exception_valid;
    logic exception_ack;
    id_t exception_id;
    exc_code_t exception_code;
    pc_t exception_tval;
    logic fetch_req;
    pc_t fetch_pc;
    logic predict_valid;
    pc_t predicted_pc;
    logic predicted_taken;
    logic tr_branch_correct;
    logic tr_branch_mispredict;
    logic tr_return_correct;
    logic tr_return_mispredict;

    int errors = 0;
    int test_errors = 0;
    int checks = 0;
    int tests = 0;

    fn3_t kind_fn3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    string kind_name [8] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu", "jal", "jalr"};

    branch_predict_top #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .INCLUDE_M_MODE(1'b1)
    ) branch_predict_top_i (
        .clk, .rst,
        .issue_new_request, .issue_id, .branch_inputs, .br_results, .branch_flush,
        .exception_valid, .exception_ack, .exception_id, .exception_code, .exception_tval,
        .fetch_req, .fetch_pc, .predict_valid, .predicted_pc, .predicted_taken,
        .tr_branch_correct, .tr_branch_mispredict, .tr_return_correct, .tr_return_mispredict
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Checks and bookkeeping
    //////////////////////////////
    task automatic compare_value(input string name, input string what, input logic [31:0] exp,
            input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0)
            $display("%s: pass", name);
        else
            $display("%s: fail, %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests++;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    // Caller sits on a rising edge
    task automatic drive_issue(input id_t id, input fn3_t fn3, input logic jal, input logic jalr,
            input logic ret, input logic [31:0] rs1, input logic [31:0] rs2, input pc_t pc,
            input logic [20:0] off);
        issue_new_request <= 1'b1;
        issue_id <= id;
        branch_inputs.rs1 <= rs1;
        branch_inputs.rs2 <= rs2;
        branch_inputs.issue_pc <= pc;
        branch_inputs.pc_p4 <= pc + 32'd4;
        branch_inputs.pc_offset <= off;
        branch_inputs.fn3 <= fn3;
        branch_inputs.jal <= jal;
        branch_inputs.jalr <= jalr;
        branch_inputs.is_call <= (jal | jalr) & ~ret;
        branch_inputs.is_return <= ret;
    endtask

    // Waits for predict_valid, then compares with the shadow BTB
    task automatic finish_lookup(input string name, input pc_t pc);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!predict_valid && waited < LOOKUP_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        checks++;
        assert (predict_valid) else begin
            $display("%s: no prediction for pc %h within %0d cycles", name, pc, LOOKUP_LIMIT);
            test_errors++;
        end
        if (predict_valid) begin
            compare_value(name, "predicted_taken", shadow_hit(pc), predicted_taken);
            compare_value(name, "predicted_pc",
                shadow_hit(pc) ? shadow_target[shadow_index(pc)] : pc + 32'd4, predicted_pc);
        end
    endtask

    task automatic lookup(input string name, input pc_t pc);
        @(posedge clk);
        fetch_req <= 1'b1;
        fetch_pc <= pc;
        @(posedge clk);
        fetch_req <= 1'b0;
        finish_lookup(name, pc);
    endtask

    // next_sel 0 same pc, 1 differs in bit 4, else differs only in bit 0
    task automatic run_branch(input string name, input fn3_t fn3, input logic jal,
            input logic jalr, input logic ret, input logic [31:0] rs1, input logic [31:0] rs2,
            input pc_t pc, input logic [20:0] off, input int next_sel, input int gap,
            input logic with_fetch);
        logic taken;
        logic flush;
        pc_t new_pc;
        pc_t next_pc;
        id_t id;
        taken = model_taken(fn3, jal, jalr, rs1, rs2);
        new_pc = model_new_pc(taken, jalr, rs1, pc, off);
        id = id_t'(next_random());
        next_pc = (next_sel == 0) ? new_pc : new_pc ^ ((next_sel == 1) ? 32'h10 : 32'h1);
        flush = (next_pc[31:1] != new_pc[31:1]);
        @(posedge clk);
        drive_issue(id, fn3, jal, jalr, ret, rs1, rs2, pc, off);
        @(posedge clk);
        issue_new_request <= 1'b0;
        repeat (gap) @(posedge clk);
        branch_inputs.issue_pc <= next_pc;
        branch_inputs.issue_pc_valid <= 1'b1;
        // Lookup meets the update on the BTB port
        if (with_fetch) begin
            fetch_req <= 1'b1;
            fetch_pc <= pc;
        end
        @(negedge clk);
        compare_value(name, "valid", 1'b1, br_results.valid);
        compare_value(name, "taken", taken, br_results.branch_taken);
        compare_value(name, "target", new_pc, br_results.target_pc);
        compare_value(name, "id", id, br_results.id);
        compare_value(name, "pc", pc, br_results.pc);
        compare_value(name, "is_branch", !(jal || jalr), br_results.is_branch);
        compare_value(name, "is_return", ret, br_results.is_return);
        compare_value(name, "is_call", (jal || jalr) && !ret, br_results.is_call);
        compare_value(name, "flush", flush, branch_flush);
        compare_value(name, "trace", 4'b1000 >> {ret, flush}, {tr_branch_correct,
            tr_branch_mispredict, tr_return_correct, tr_return_mispredict});
        shadow_write(pc, taken, new_pc);
        @(posedge clk);
        branch_inputs.issue_pc_valid <= 1'b0;
        fetch_req <= 1'b0;
    endtask

    task automatic run_misaligned(input string name);
        pc_t target;
        target = model_new_pc(1'b1, 1'b0, 32'd0, 32'h0000_2000, 21'h102);
        @(posedge clk);
        drive_issue(3'd5, 3'b000, 1'b1, 1'b0, 1'b0, 32'd0, 32'd0, 32'h0000_2000, 21'h102);
        @(posedge clk);
        issue_new_request <= 1'b0;
        @(negedge clk);
        compare_value(name, "exception_valid", 1'b1, exception_valid);
        compare_value(name, "exception_code", INST_ADDR_MISALIGNED, exception_code);
        compare_value(name, "exception_tval", target, exception_tval);
        compare_value(name, "exception_id", 3'd5, exception_id);
        repeat (3) begin
            @(negedge clk);
            compare_value(name, "exception_hold", 1'b1, exception_valid);
        end
        // Exception has already dropped the pending branch
        @(posedge clk);
        exception_ack <= 1'b1;
        branch_inputs.issue_pc <= target;
        branch_inputs.issue_pc_valid <= 1'b1;
        @(negedge clk);
        compare_value(name, "exception_at_ack", 1'b1, exception_valid);
        compare_value(name, "killed_valid", 1'b0, br_results.valid);
        @(posedge clk);
        exception_ack <= 1'b0;
        branch_inputs.issue_pc_valid <= 1'b0;
        @(negedge clk);
        compare_value(name, "exception_cleared", 1'b0, exception_valid);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int k;
        int n;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        rst = 1'b1;
        issue_new_request = 1'b0;
        issue_id = '0;
        branch_inputs = '0;
        exception_ack = 1'b0;
        fetch_req = 1'b0;
        fetch_pc = '0;
        shadow_clear();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // First lookup stalls until the table sweep ends
        lookup("sweep", 32'h0000_0100);
        end_test("sweep");
        for (k = 0; k < 8; k++) begin
            for (n = 0; n < ITER; n++) begin
                a = next_random();
                b = next_random();
                r = next_random();
                if (r[0])
                    b = a;
                // Bit 1 clear keeps jalr targets clear of the exception
                // Bit 0 may stay set so jalr has to drop it
                if (k == 7)
                    a = a & ~32'h2;
                run_branch(kind_name[k], (k < 6) ? kind_fn3[k] : 3'b000, k == 6, k == 7,
                    (k == 7) & r[1], a, b, next_random() & ~32'h3, r[26:6] & 21'h1ffffc,
                    int'(r[3:2]), int'(r[5:4]), 1'b0);
            end
            end_test(kind_name[k]);
        end
        run_misaligned("misaligned");
        end_test("misaligned");
        // Taken, then the same pc not taken
        run_branch("btb_train", 3'b000, 1'b1, 1'b0, 1'b0, 32'd0, 32'd0, TRAIN_PC, 21'h200,
            0, 0, 1'b0);
        repeat (3) @(posedge clk);
        lookup("btb_train", TRAIN_PC);
        run_branch("btb_train", 3'b000, 1'b0, 1'b0, 1'b0, 32'd1, 32'd2, TRAIN_PC, 21'h200,
            0, 0, 1'b0);
        repeat (3) @(posedge clk);
        lookup("btb_train", TRAIN_PC);
        end_test("btb_train");
        // Stale entry first, so a lookup that beat the update would read it
        run_branch("arbitration", 3'b000, 1'b1, 1'b0, 1'b0, 32'd0, 32'd0, ARB_PC, 21'h80,
            0, 0, 1'b0);
        run_branch("arbitration", 3'b000, 1'b1, 1'b0, 1'b0, 32'd0, 32'd0, ARB_PC, 21'h400,
            1, 1, 1'b1);
        finish_lookup("arbitration", ARB_PC);
        end_test("arbitration");
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+testbench
source/riscv_branch_pkg.sv
source/branch_predict_pkg.sv
source/branch_unit.sv
source/btb_arbiter.sv
source/btb_ram.sv
source/fetch_predictor.sv
source/branch_predict_top.sv
testbench/tb_branch_predict_top.sv

// File: Bender.yml
package:
  name: branch_predict

sources:
  # Packages first, then the RTL from the leaves up to the top level
  - files:
      - source/riscv_branch_pkg.sv
      - source/branch_predict_pkg.sv
      - source/branch_unit.sv
      - source/btb_arbiter.sv
      - source/btb_ram.sv
      - source/fetch_predictor.sv
      - source/branch_predict_top.sv

  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_branch_predict_top.sv
